/* common/scope_pkg.sv */
// scope controller shared definitions
// widths, threshold arithmetic constants, opcode and state enums
`default_nettype none

package scope_pkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------
	localparam int BYTE_W    = 8;   // command stream byte
	localparam int CMD_BYTES = 8;   // bytes per command frame
	localparam int WORD_W    = 32;  // reply word
	localparam int KEEP_W    = 4;   // reply byte enables
	localparam int SAMPLE_W  = 12;  // signed adc sample
	localparam int CNT_W     = 16;  // post-trigger and event counters
	localparam int N_OVR     = 4;   // overrange lines

	localparam int FW_VERSION = 17; // returned by info/version

	// threshold byte arithmetic, result in sample units
	localparam int THRESH_MID   = 128;
	localparam int THRESH_SHIFT = 4;
	localparam int THRESH_BIAS  = 8;

	// --------------------------------------------------
	// enums
	// --------------------------------------------------
	typedef enum logic [7:0] {
		OP_ARM       = 8'd1,  // arm / status
		OP_INFO      = 8'd2,  // version, board in, overrange
		OP_TRIG_SET  = 8'd8,  // thresholds, tot, take length
		OP_BOARD_OUT = 8'd10  // single board output bit
	} opcode_e;

	typedef enum logic [7:0] {
		INFO_VERSION   = 8'd0,
		INFO_BOARD_IN  = 8'd1,
		INFO_OVERRANGE = 8'd2
	} info_sel_e;

	typedef enum logic [7:0] {
		TRIG_FREE    = 8'd0, // also any unknown code
		TRIG_FALLING = 8'd1,
		TRIG_RISING  = 8'd2
	} trig_type_e;

	typedef enum logic [2:0] {
		ACQ_READY,     // idle, waiting for arm
		ACQ_FALL_LOW,  // falling: wait below lower
		ACQ_FALL_HIGH, // falling: tot above upper
		ACQ_RISE_HIGH, // rising: wait above upper
		ACQ_RISE_LOW,  // rising: tot below lower
		ACQ_POST,      // counting post-trigger samples
		ACQ_DONE       // event complete, waits for arm
	} acq_state_e;

endpackage

`default_nettype wire

/* hw/cmd_frame_rx.sv */
// command frame receiver
// gathers eight stream bytes into one frame, held until the executor takes it
`timescale 1ns/1ns
`default_nettype none

module cmd_frame_rx (
	input  logic                                          clk,
	input  logic                                          rstn,
	// byte stream in
	input  logic                                          i_tvalid,
	output logic                                          o_tready,
	input  logic [scope_pkg::BYTE_W-1:0]                  i_tdata,
	// frame hand-off to executor
	output logic                                          o_frame_valid,
	input  logic                                          i_frame_ready,
	output logic [scope_pkg::CMD_BYTES-1:0][scope_pkg::BYTE_W-1:0] o_frame
);
	import scope_pkg::*;

	logic [$clog2(CMD_BYTES)-1:0] byte_idx; // next byte slot
	logic                         full;     // frame complete and held
	logic                         byte_take;

	assign o_tready      = !full;           // stall stream while holding
	assign o_frame_valid = full;
	assign byte_take     = i_tvalid && o_tready;

	// --------------------------------------------------
	// index and full flag
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			byte_idx <= '0;
			full     <= 1'b0;
		end else begin
			if (byte_take) begin
				byte_idx <= byte_idx + 1'b1;         // wraps after last byte
				if (byte_idx == CMD_BYTES - 1)
					full <= 1'b1;                    // eighth byte taken
			end else if (full && i_frame_ready) begin
				full <= 1'b0;                        // executor took it
			end
		end
	end

	// frame payload, byte 0 is the opcode
	always_ff @(posedge clk) begin
		if (byte_take)
			o_frame[byte_idx] <= i_tdata;
	end

endmodule

`default_nettype wire

/* acq/acq_trigger.sv */
// acquisition engine
// threshold trigger fsm with time over threshold, post-trigger and event counters,
// per-line overrange counters
`timescale 1ns/1ns
`default_nettype none

module acq_trigger (
	input  logic                                           clk,
	input  logic                                           rstn,
	input  logic                                           i_sample_valid,
	input  logic signed [scope_pkg::SAMPLE_W-1:0]          i_sample,
	input  logic [scope_pkg::N_OVR-1:0]                    i_overrange,
	// settings from executor
	input  logic                                           i_arm,
	input  scope_pkg::trig_type_e                          i_trig_type,
	input  logic signed [scope_pkg::SAMPLE_W-1:0]          i_lower_thresh,
	input  logic signed [scope_pkg::SAMPLE_W-1:0]          i_upper_thresh,
	input  logic [scope_pkg::BYTE_W-1:0]                   i_trig_tot,
	input  logic [scope_pkg::CNT_W-1:0]                    i_take_len,
	// status
	output logic [scope_pkg::CNT_W-1:0]                    o_event_count,
	output logic [scope_pkg::CNT_W-1:0]                    o_post_count,
	output logic [scope_pkg::N_OVR-1:0][scope_pkg::WORD_W-1:0] o_ovr_counts
);
	import scope_pkg::*;

	acq_state_e        state;
	logic [BYTE_W-1:0] tot_cnt;  // second-condition samples seen
	logic              below;    // valid sample under lower threshold
	logic              above;    // valid sample over upper threshold

	assign below = i_sample_valid && (i_sample < i_lower_thresh);
	assign above = i_sample_valid && (i_sample > i_upper_thresh);

	// --------------------------------------------------
	// trigger fsm
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state         <= ACQ_READY;
			tot_cnt       <= '0;
			o_post_count  <= '0;
			o_event_count <= '0;
		end else begin
			case (state)
				ACQ_READY: begin
					tot_cnt <= '0;
					if (i_arm) begin
						case (i_trig_type)
							TRIG_FALLING: state <= ACQ_FALL_LOW;
							TRIG_RISING:  state <= ACQ_RISE_HIGH;
							default:      state <= ACQ_POST;   // free-run
						endcase
					end
				end
				ACQ_FALL_LOW: if (below) state <= ACQ_FALL_HIGH;
				ACQ_FALL_HIGH: begin
					if (above) begin
						tot_cnt <= tot_cnt + 1'b1;
						if (tot_cnt >= i_trig_tot)
							state <= ACQ_POST;               // tot+1 samples over
					end
				end
				ACQ_RISE_HIGH: if (above) state <= ACQ_RISE_LOW;
				ACQ_RISE_LOW: begin
					if (below) begin
						tot_cnt <= tot_cnt + 1'b1;
						if (tot_cnt >= i_trig_tot)
							state <= ACQ_POST;
					end
				end
				ACQ_POST: begin
					if (o_post_count != i_take_len) begin
						if (i_sample_valid)
							o_post_count <= o_post_count + 1'b1;
					end else begin
						o_event_count <= o_event_count + 1'b1;
						o_post_count  <= '1;                 // all ones marks done
						state         <= ACQ_DONE;
					end
				end
				ACQ_DONE: begin
					if (i_arm) begin                         // release, no new search
						o_post_count <= '0;
						state        <= ACQ_READY;
					end
				end
				default: state <= ACQ_READY;
			endcase
		end
	end

	// --------------------------------------------------
	// overrange counters, one per line, wrapping
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_ovr_counts <= '0;
		end else begin
			for (int i = 0; i < N_OVR; i++) begin
				if (i_overrange[i])
					o_ovr_counts[i] <= o_ovr_counts[i] + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/cmd_executor.sv */
// command executor
// opcode decode, trigger settings and board output registers,
// arm pulse, single-beat reply stream
`timescale 1ns/1ns
`default_nettype none

module cmd_executor (
	input  logic                                           clk,
	input  logic                                           rstn,
	// frame from receiver
	input  logic                                           i_frame_valid,
	output logic                                           o_frame_ready,
	input  logic [scope_pkg::CMD_BYTES-1:0][scope_pkg::BYTE_W-1:0] i_frame,
	// acquisition status
	input  logic [scope_pkg::CNT_W-1:0]                    i_event_count,
	input  logic [scope_pkg::CNT_W-1:0]                    i_post_count,
	input  logic [scope_pkg::N_OVR-1:0][scope_pkg::WORD_W-1:0] i_ovr_counts,
	input  logic [scope_pkg::BYTE_W-1:0]                   i_board_in,
	// acquisition control
	output logic                                           o_arm,
	output scope_pkg::trig_type_e                          o_trig_type,
	output logic signed [scope_pkg::SAMPLE_W-1:0]          o_lower_thresh,
	output logic signed [scope_pkg::SAMPLE_W-1:0]          o_upper_thresh,
	output logic [scope_pkg::BYTE_W-1:0]                   o_trig_tot,
	output logic [scope_pkg::CNT_W-1:0]                    o_take_len,
	output logic [scope_pkg::BYTE_W-1:0]                   o_board_out,
	// reply stream
	output logic                                           o_rvalid,
	input  logic                                           i_rready,
	output logic [scope_pkg::WORD_W-1:0]                   o_rdata,
	output logic [scope_pkg::KEEP_W-1:0]                   o_rkeep,
	output logic                                           o_rlast
);
	import scope_pkg::*;

	opcode_e                    op;
	logic                       accept;       // frame taken this cycle
	logic                       reply_en;     // opcode produces a reply
	logic [WORD_W-1:0]          reply_word;
	logic [BYTE_W-1:0]          board_next;   // board_out after the write
	logic signed [SAMPLE_W-1:0] thresh_lo;
	logic signed [SAMPLE_W-1:0] thresh_hi;

	assign op            = opcode_e'(i_frame[0]);
	assign o_frame_ready = !o_rvalid;           // one reply outstanding at most
	assign accept        = i_frame_valid && o_frame_ready;
	assign o_arm         = accept && (op == OP_ARM); // same cycle as status capture
	assign o_rkeep       = '1;                  // every reply is one full beat
	assign o_rlast       = 1'b1;

	// --------------------------------------------------
	// reply and setting computation
	// --------------------------------------------------
	always_comb begin
		board_next                 = o_board_out;
		board_next[i_frame[1][2:0]] = i_frame[2][0];
		// byte thresholds into sample units, mod 2^SAMPLE_W
		thresh_lo = SAMPLE_W'(((int'(i_frame[1]) - int'(i_frame[2]) - THRESH_MID)
			<< THRESH_SHIFT) + THRESH_BIAS);
		thresh_hi = SAMPLE_W'(((int'(i_frame[1]) + int'(i_frame[2]) - THRESH_MID)
			<< THRESH_SHIFT) + THRESH_BIAS);
	end

	always_comb begin
		reply_en   = 1'b1;
		reply_word = '0;
		case (op)
			OP_ARM:  reply_word = {i_event_count, i_post_count};
			OP_INFO: begin
				case (info_sel_e'(i_frame[1]))
					INFO_VERSION:   reply_word = WORD_W'(FW_VERSION);
					INFO_BOARD_IN:  reply_word = {4{i_board_in}};
					INFO_OVERRANGE: reply_word = i_ovr_counts[i_frame[2][1:0]];
					default:        reply_word = '0;     // unknown selector
				endcase
			end
			OP_TRIG_SET:  reply_word = WORD_W'(OP_TRIG_SET); // echoes 8
			OP_BOARD_OUT: reply_word = WORD_W'(board_next);
			default:      reply_en   = 1'b0;           // swallowed silently
		endcase
	end

	// --------------------------------------------------
	// control and settings registers
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_rvalid       <= 1'b0;
			o_trig_type    <= TRIG_FREE;
			o_lower_thresh <= '0;
			o_upper_thresh <= '0;
			o_trig_tot     <= '0;
			o_take_len     <= '0;
			o_board_out    <= '0;
		end else begin
			if (accept && reply_en)
				o_rvalid <= 1'b1;
			else if (i_rready)
				o_rvalid <= 1'b0;                     // beat delivered
			if (accept && op == OP_TRIG_SET) begin
				o_trig_type    <= trig_type_e'(i_frame[6]);
				o_lower_thresh <= thresh_lo;
				o_upper_thresh <= thresh_hi;
				o_trig_tot     <= i_frame[5];
				o_take_len     <= {i_frame[4], i_frame[3]}; // high, low
			end
			if (accept && op == OP_BOARD_OUT)
				o_board_out <= board_next;
		end
	end

	// reply payload, captured at acceptance
	always_ff @(posedge clk) begin
		if (accept)
			o_rdata <= reply_word;
	end

endmodule

`default_nettype wire

/* hw/scope_ctrl_top.sv */
// scope controller top level
// frame receiver, acquisition engine and command executor
`timescale 1ns/1ns
`default_nettype none

module scope_ctrl_top (
	input  logic                                  clk,
	input  logic                                  rstn,
	// command byte stream
	input  logic                                  i_tvalid,
	output logic                                  o_tready,
	input  logic [scope_pkg::BYTE_W-1:0]          i_tdata,
	// adc samples and overrange lines
	input  logic                                  i_sample_valid,
	input  logic signed [scope_pkg::SAMPLE_W-1:0] i_sample,
	input  logic [scope_pkg::N_OVR-1:0]           i_overrange,
	// board io
	input  logic [scope_pkg::BYTE_W-1:0]          i_board_in,
	output logic [scope_pkg::BYTE_W-1:0]          o_board_out,
	// reply stream
	output logic                                  o_rvalid,
	input  logic                                  i_rready,
	output logic [scope_pkg::WORD_W-1:0]          o_rdata,
	output logic [scope_pkg::KEEP_W-1:0]          o_rkeep,
	output logic                                  o_rlast
);
	import scope_pkg::*;

	// --------------------------------------------------
	// internal nets
	// --------------------------------------------------
	logic                                frame_valid;
	logic                                frame_ready;
	logic [CMD_BYTES-1:0][BYTE_W-1:0]    frame;
	logic [CNT_W-1:0]                    event_count;
	logic [CNT_W-1:0]                    post_count;
	logic [N_OVR-1:0][WORD_W-1:0]        ovr_counts;
	logic                                arm;
	trig_type_e                          trig_type;
	logic signed [SAMPLE_W-1:0]          lower_thresh;
	logic signed [SAMPLE_W-1:0]          upper_thresh;
	logic [BYTE_W-1:0]                   trig_tot;
	logic [CNT_W-1:0]                    take_len;

	cmd_frame_rx u_rx (
		.clk           (clk),
		.rstn          (rstn),
		.i_tvalid      (i_tvalid),
		.o_tready      (o_tready),
		.i_tdata       (i_tdata),
		.o_frame_valid (frame_valid),
		.i_frame_ready (frame_ready),
		.o_frame       (frame)
	);

	acq_trigger u_acq (
		.clk            (clk),
		.rstn           (rstn),
		.i_sample_valid (i_sample_valid),
		.i_sample       (i_sample),
		.i_overrange    (i_overrange),
		.i_arm          (arm),
		.i_trig_type    (trig_type),
		.i_lower_thresh (lower_thresh),
		.i_upper_thresh (upper_thresh),
		.i_trig_tot     (trig_tot),
		.i_take_len     (take_len),
		.o_event_count  (event_count),
		.o_post_count   (post_count),
		.o_ovr_counts   (ovr_counts)
	);

	cmd_executor u_exec (
		.clk            (clk),
		.rstn           (rstn),
		.i_frame_valid  (frame_valid),
		.o_frame_ready  (frame_ready),
		.i_frame        (frame),
		.i_event_count  (event_count),
		.i_post_count   (post_count),
		.i_ovr_counts   (ovr_counts),
		.i_board_in     (i_board_in),
		.o_arm          (arm),
		.o_trig_type    (trig_type),
		.o_lower_thresh (lower_thresh),
		.o_upper_thresh (upper_thresh),
		.o_trig_tot     (trig_tot),
		.o_take_len     (take_len),
		.o_board_out    (o_board_out),
		.o_rvalid       (o_rvalid),
		.i_rready       (i_rready),
		.o_rdata        (o_rdata),
		.o_rkeep        (o_rkeep),
		.o_rlast        (o_rlast)
	);

endmodule

`default_nettype wire

/* bench/tb_clkgen.sv */
// testbench clock and reset source
// 8 ns clock, active-low reset held for four cycles
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
	output logic clk,
	output logic rstn
);
	localparam int PERIOD     = 8;
	localparam int RST_CYCLES = 4;

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		rstn = 1'b0;                          // asserted from time zero
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;                          // released mid-cycle
	end

endmodule

`default_nettype wire

/* bench/scope_ctrl_tb.sv */
// scope controller testbench
// random commands, samples and overrange pulses against a reference model,
// reply monitor with back-pressure, compare tasks and cycle timeout
`timescale 1ns/1ns
`default_nettype none

module scope_ctrl_tb;
	import scope_pkg::*;

	// --------------------------------------------------
	// run length and timeout
	// --------------------------------------------------
	localparam int N_BOARD_CMDS  = 24;
	localparam int OVR_CYC_MAX   = 150;
	localparam int N_ROUNDS      = 3;    // per trigger type
	localparam int ROUND_SAMPLES = 100;
	localparam int FINISH_MAX    = 64;   // cycles to drive the model to done
	localparam int N_CMDS        = 16 + 2 * N_BOARD_CMDS + 8 * N_ROUNDS;
	localparam int CMD_CYC       = 64;   // per command, gaps and stalls included
	localparam int TIMEOUT_CYC   = 2 * (N_CMDS * CMD_CYC + OVR_CYC_MAX + 64
		+ 2 * N_ROUNDS * (ROUND_SAMPLES + FINISH_MAX + 32));

	logic                       clk;
	logic                       rstn;
	logic                       i_tvalid;
	logic                       o_tready;
	logic [BYTE_W-1:0]          i_tdata;
	logic                       i_sample_valid;
	logic signed [SAMPLE_W-1:0] i_sample;
	logic [N_OVR-1:0]           i_overrange;
	logic [BYTE_W-1:0]          i_board_in;
	logic [BYTE_W-1:0]          o_board_out;
	logic                       o_rvalid;
	logic                       i_rready;
	logic [WORD_W-1:0]          o_rdata;
	logic [KEEP_W-1:0]          o_rkeep;
	logic                       o_rlast;

	// reference model state
	logic [BYTE_W-1:0]          m_board_out;
	logic [BYTE_W-1:0]          m_trig_type;
	logic signed [SAMPLE_W-1:0] m_lower;
	logic signed [SAMPLE_W-1:0] m_upper;
	logic [BYTE_W-1:0]          m_tot;
	logic [CNT_W-1:0]           m_take;
	logic [CNT_W-1:0]           m_post;
	logic [CNT_W-1:0]           m_event;
	acq_state_e                 m_state;
	int                         m_tot_cnt;
	logic [WORD_W-1:0]          m_ovr [N_OVR];

	logic [WORD_W-1:0]          exp_q [$];     // replies in command order
	int seed         = 34319;
	int value_errors = 0;
	int proto_errors = 0;
	int replies      = 0;
	int n_expected   = 0;
	int cycles       = 0;

	tb_clkgen u_clkgen (.clk(clk), .rstn(rstn));

	scope_ctrl_top UUT (
		.clk(clk), .rstn(rstn),
		.i_tvalid(i_tvalid), .o_tready(o_tready), .i_tdata(i_tdata),
		.i_sample_valid(i_sample_valid), .i_sample(i_sample), .i_overrange(i_overrange),
		.i_board_in(i_board_in), .o_board_out(o_board_out),
		.o_rvalid(o_rvalid), .i_rready(i_rready), .o_rdata(o_rdata),
		.o_rkeep(o_rkeep), .o_rlast(o_rlast)
	);

	// --------------------------------------------------
	// compare tasks
	// --------------------------------------------------
	task automatic check_word(input string name, input logic [WORD_W-1:0] exp,
		input logic [WORD_W-1:0] act);
		if (act !== exp) begin
			value_errors++;
			$display("[FAIL] %s expected 0x%h got 0x%h", name, exp, act);
		end
	endtask

	task automatic check_beat_flags(input logic [KEEP_W-1:0] keep, input logic last);
		if (keep !== {KEEP_W{1'b1}}) begin
			value_errors++;
			$display("[FAIL] o_rkeep expected 0x%h got 0x%h", {KEEP_W{1'b1}}, keep);
		end
		if (last !== 1'b1) begin
			value_errors++;
			$display("[FAIL] o_rlast expected 0x1 got 0x%h", last);
		end
	endtask

	task automatic check_byte(input string name, input logic [BYTE_W-1:0] exp,
		input logic [BYTE_W-1:0] act);
		if (act !== exp) begin
			value_errors++;
			$display("[FAIL] %s expected 0x%h got 0x%h", name, exp, act);
		end
	endtask

	task automatic report_counts();
		$display("errors: value %0d, protocol %0d, replies %0d of %0d",
			value_errors, proto_errors, replies, n_expected);
	endtask

	// --------------------------------------------------
	// reference model of the acquisition engine
	// --------------------------------------------------
	function automatic logic signed [SAMPLE_W-1:0] thresh_of(input logic [BYTE_W-1:0] b1,
		input logic [BYTE_W-1:0] b2, input logic add);
		int v;
		v = add ? int'(b1) + int'(b2) : int'(b1) - int'(b2);
		v = (v - THRESH_MID) * (1 << THRESH_SHIFT) + THRESH_BIAS;
		return v[SAMPLE_W-1:0];                 // wraps to sample width
	endfunction

	function automatic void model_settle();
		if (m_state == ACQ_POST && m_post == m_take) begin
			m_event++;
			m_post  = '1;                       // done marker
			m_state = ACQ_DONE;
		end
	endfunction

	function automatic void model_arm();
		if (m_state == ACQ_READY) begin
			m_tot_cnt = 0;
			case (m_trig_type)
				8'd1:    m_state = ACQ_FALL_LOW;
				8'd2:    m_state = ACQ_RISE_HIGH;
				default: m_state = ACQ_POST;        // free-run
			endcase
		end else if (m_state == ACQ_DONE) begin
			m_post  = '0;
			m_state = ACQ_READY;                // release only
		end
		model_settle();
	endfunction

	function automatic void model_sample(input logic signed [SAMPLE_W-1:0] s);
		case (m_state)
			ACQ_FALL_LOW:  if (s < m_lower) m_state = ACQ_FALL_HIGH;
			ACQ_FALL_HIGH: begin
				if (s > m_upper) begin
					if (m_tot_cnt >= int'(m_tot)) m_state = ACQ_POST;
					m_tot_cnt++;
				end
			end
			ACQ_RISE_HIGH: if (s > m_upper) m_state = ACQ_RISE_LOW;
			ACQ_RISE_LOW: begin
				if (s < m_lower) begin
					if (m_tot_cnt >= int'(m_tot)) m_state = ACQ_POST;
					m_tot_cnt++;
				end
			end
			ACQ_POST: m_post++;
			default: ;
		endcase
		model_settle();
	endfunction

	// sample bands relative to the model thresholds
	function automatic logic signed [SAMPLE_W-1:0] pick_below();
		return SAMPLE_W'(int'(m_lower) - 1 - int'({$random(seed)} % 200));
	endfunction

	function automatic logic signed [SAMPLE_W-1:0] pick_above();
		return SAMPLE_W'(int'(m_upper) + 1 + int'({$random(seed)} % 200));
	endfunction

	function automatic logic signed [SAMPLE_W-1:0] pick_between();
		int span;
		span = int'(m_upper) - int'(m_lower) + 1;
		if (span < 1)
			span = 1;
		return SAMPLE_W'(int'(m_lower) + int'({$random(seed)} % span));
	endfunction

	// --------------------------------------------------
	// command stream
	// --------------------------------------------------
	task automatic send_frame(input logic [CMD_BYTES-1:0][BYTE_W-1:0] f);
		logic taken;
		for (int i = 0; i < CMD_BYTES; i++) begin
			while (({$random(seed)} % 4) == 0) begin   // idle gap
				i_tvalid = 1'b0;
				@(negedge clk);
			end
			i_tvalid = 1'b1;
			i_tdata  = f[i];
			taken    = 1'b0;
			while (!taken) begin
				taken = o_tready;                        // stable in low phase
				@(negedge clk);
			end
		end
		i_tvalid = 1'b0;
	endtask

	task automatic send_cmd(input logic [BYTE_W-1:0] op, input logic [BYTE_W-1:0] b1,
		input logic [BYTE_W-1:0] b2, input logic has_reply, input logic [WORD_W-1:0] exp);
		logic [CMD_BYTES-1:0][BYTE_W-1:0] f;
		f    = {$random(seed), $random(seed)};    // unused bytes random
		f[0] = op;
		f[1] = b1;
		f[2] = b2;
		if (has_reply) begin
			exp_q.push_back(exp);
			n_expected++;
		end
		send_frame(f);
	endtask

	task automatic set_trigger(input logic [BYTE_W-1:0] b1, input logic [BYTE_W-1:0] b2,
		input logic [BYTE_W-1:0] b3, input logic [BYTE_W-1:0] b4,
		input logic [BYTE_W-1:0] b5, input logic [BYTE_W-1:0] b6);
		logic [CMD_BYTES-1:0][BYTE_W-1:0] f;
		f = {$random(seed), $random(seed)};
		f[0] = OP_TRIG_SET;
		f[1] = b1;
		f[2] = b2;
		f[3] = b3;
		f[4] = b4;
		f[5] = b5;
		f[6] = b6;
		m_trig_type = b6;
		m_lower     = thresh_of(b1, b2, 1'b0);
		m_upper     = thresh_of(b1, b2, 1'b1);
		m_tot       = b5;
		m_take      = {b4, b3};                 // high, low
		exp_q.push_back(WORD_W'(8));
		n_expected++;
		send_frame(f);
	endtask

	task automatic arm_and_check();
		send_cmd(OP_ARM, 8'($random(seed)), 8'($random(seed)), 1'b1, {m_event, m_post});
		model_arm();
	endtask

	task automatic drain();
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);              // room for a stray reply
	endtask

	// --------------------------------------------------
	// sample stimulus
	// --------------------------------------------------
	task automatic stream_samples(input int n);
		int band;
		repeat (n) begin
			i_sample_valid = ({$random(seed)} % 4) != 0;
			band           = {$random(seed)} % 3;
			case (band)
				0:       i_sample = pick_below();
				1:       i_sample = pick_between();
				default: i_sample = pick_above();
			endcase
			if (i_sample_valid)
				model_sample(i_sample);
			@(negedge clk);
		end
		i_sample_valid = 1'b0;
	endtask

	task automatic run_to_done();
		int guard;
		guard = 0;
		while (m_state != ACQ_DONE && m_state != ACQ_READY && guard < FINISH_MAX) begin
			i_sample_valid = 1'b1;
			case (m_state)
				ACQ_FALL_LOW, ACQ_RISE_LOW:   i_sample = pick_below();
				ACQ_FALL_HIGH, ACQ_RISE_HIGH: i_sample = pick_above();
				default:                      i_sample = pick_between();
			endcase
			model_sample(i_sample);
			guard++;
			@(negedge clk);
		end
		i_sample_valid = 1'b0;
		if (m_state != ACQ_DONE) begin
			proto_errors++;
			$display("acquisition did not reach the done state within %0d samples", FINISH_MAX);
		end
	endtask

	// --------------------------------------------------
	// tests
	// --------------------------------------------------
	task automatic info_test();
		send_cmd(OP_INFO, INFO_VERSION, 8'($random(seed)), 1'b1, WORD_W'(17));
		send_cmd(OP_INFO, INFO_BOARD_IN, 8'($random(seed)), 1'b1, {4{i_board_in}});
		send_cmd(OP_INFO, 8'(3 + {$random(seed)} % 253), 8'd0, 1'b1, '0); // unknown selector
		drain();
	endtask

	task automatic board_out_test();
		logic [BYTE_W-1:0] b1;
		logic [BYTE_W-1:0] b2;
		repeat (N_BOARD_CMDS) begin
			if (({$random(seed)} % 6) == 0)
				send_cmd(8'h80 | 8'($random(seed)), 8'd0, 8'd0, 1'b0, '0); // no reply
			b1 = 8'($random(seed));
			b2 = 8'($random(seed));
			m_board_out[b1[2:0]] = b2[0];
			send_cmd(OP_BOARD_OUT, b1, b2, 1'b1, WORD_W'(m_board_out));
			drain();
			check_byte("o_board_out", m_board_out, o_board_out); // after each write
		end
	endtask

	task automatic overrange_test();
		int n;
		n = 20 + {$random(seed)} % (OVR_CYC_MAX - 20);
		repeat (n) begin
			i_overrange = N_OVR'($random(seed));
			for (int i = 0; i < N_OVR; i++)
				if (i_overrange[i])
					m_ovr[i]++;
			@(negedge clk);
		end
		i_overrange = '0;                       // counts frozen from here
		for (int i = 0; i < N_OVR; i++)
			send_cmd(OP_INFO, INFO_OVERRANGE, {6'($random(seed)), 2'(i)}, 1'b1, m_ovr[i]);
		drain();
	endtask

	task automatic free_run_test();
		logic [BYTE_W-1:0] ttype;
		logic [BYTE_W-1:0] take_lo;
		ttype   = (({$random(seed)} % 2) == 0) ? 8'd0 : 8'(3 + {$random(seed)} % 250);
		take_lo = 8'(1 + {$random(seed)} % 20);
		set_trigger(8'($random(seed)), 8'($random(seed)), take_lo, 8'd0,
			8'($random(seed)), ttype);
		arm_and_check();
		drain();
		repeat (int'(take_lo) + 5) begin        // more than the take length
			i_sample_valid = 1'b1;
			i_sample       = SAMPLE_W'($random(seed));
			model_sample(i_sample);
			@(negedge clk);
		end
		i_sample_valid = 1'b0;
		arm_and_check();                        // done status, releases
		drain();
		arm_and_check();                        // post count back to zero
		drain();
	endtask

	task automatic trigger_round(input logic [BYTE_W-1:0] ttype);
		logic [BYTE_W-1:0] b1;
		logic [BYTE_W-1:0] b2;
		b1 = 8'(100 + {$random(seed)} % 57);
		b2 = 8'(5 + {$random(seed)} % 16);     // keeps lower below upper
		set_trigger(b1, b2, 8'(1 + {$random(seed)} % 30), 8'd0,
			8'({$random(seed)} % 4), ttype);
		arm_and_check();
		drain();
		stream_samples(20 + {$random(seed)} % (ROUND_SAMPLES - 20));
		arm_and_check();                        // status read after the stream
		drain();
		if (m_state != ACQ_READY) begin
			run_to_done();
			arm_and_check();
			drain();
		end
	endtask

	// --------------------------------------------------
	// reply monitor, back-pressure on i_rready
	// --------------------------------------------------
	initial begin : reply_monitor
		logic [WORD_W-1:0] exp_word;
		i_rready = 1'b0;
		@(posedge rstn);
		forever begin
			@(negedge clk);
			i_rready = ({$random(seed)} % 4) != 0;
			#1;
			if (o_rvalid && i_rready) begin       // beat moves on next rising edge
				replies++;
				if (exp_q.size() == 0) begin
					proto_errors++;
					$display("reply 0x%h arrived with no command waiting for one", o_rdata);
				end else begin
					exp_word = exp_q.pop_front();
					check_word("o_rdata", exp_word, o_rdata);
					check_beat_flags(o_rkeep, o_rlast);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYC) begin
			$display("run timed out after %0d cycles", cycles);
			report_counts();
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin : main_sequence
		i_tvalid       = 1'b0;
		i_tdata        = '0;
		i_sample_valid = 1'b0;
		i_sample       = '0;
		i_overrange    = '0;
		i_board_in     = 8'($random(seed));
		m_board_out    = '0;
		m_trig_type    = '0;
		m_lower        = '0;
		m_upper        = '0;
		m_tot          = '0;
		m_take         = '0;
		m_post         = '0;
		m_event        = '0;
		m_state        = ACQ_READY;
		m_tot_cnt      = 0;
		for (int i = 0; i < N_OVR; i++)
			m_ovr[i] = '0;
		@(posedge rstn);
		@(negedge clk);
		info_test();
		board_out_test();
		overrange_test();
		free_run_test();
		for (int r = 0; r < N_ROUNDS; r++) begin
			trigger_round(8'(TRIG_FALLING));
			trigger_round(8'(TRIG_RISING));
		end
		drain();
		if (replies != n_expected) begin
			proto_errors++;
			$display("reply count %0d does not match %0d commands", replies, n_expected);
		end
		report_counts();
		if (value_errors == 0 && proto_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
common/scope_pkg.sv
hw/cmd_frame_rx.sv
acq/acq_trigger.sv
hw/cmd_executor.sv
hw/scope_ctrl_top.sv
bench/tb_clkgen.sv
bench/scope_ctrl_tb.sv

/* Makefile */
# Verilator build and run of the scope controller testbench

VERILATOR ?= verilator
TOP       ?= scope_ctrl_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status follows the pass message in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
